// File: fetch_consts.svh
// fetch unit constants: line geometry, slot count and datapath widths
`ifndef FETCH_CONSTS_SVH
`define FETCH_CONSTS_SVH

// bytes per cache line, also the size of the decoder window
`define FETCH_LINE_BYTES 16

// one line in bits
`define FETCH_LINE_W 128

// line buffer depth
`define FETCH_SLOTS 4
`define FETCH_SLOT_W 2

// byte read pointer over the whole 64-byte buffer
`define FETCH_PTR_W 6

// linear address and EIP
`define FETCH_ADDR_W 32

// code segment selector
`define FETCH_SEG_W 16

// x86 instruction length, 1 to 15
`define FETCH_LEN_W 4

// number of filled slots, 0 to 4
`define FETCH_CNT_W 3

`endif

// File: fetch_pkg.sv
// fetch unit types shared by the RTL and the testbench
`include "fetch_consts.svh"

package fetch_pkg;

   // line-aligned request to the instruction cache
   typedef struct packed {
      logic [`FETCH_ADDR_W-1:0] addr;
   } icache_req_t;

   // one full line back from the instruction cache
   typedef struct packed {
      logic [`FETCH_LINE_W-1:0] data;
   } icache_resp_t;

   // flush or taken jump target
   typedef struct packed {
      logic [`FETCH_ADDR_W-1:0] eip;
      logic [`FETCH_SEG_W-1:0]  cs;
   } redirect_t;

   // window handed to the decoder, byte 0 is the current instruction byte
   typedef struct packed {
      logic [`FETCH_LINE_W-1:0] bytes;
      logic [`FETCH_ADDR_W-1:0] eip;
   } fetch_window_t;

   // the four line slots, slot i at index i
   typedef logic [`FETCH_SLOTS-1:0][`FETCH_LINE_W-1:0] line_array_t;

endpackage

// File: fetch_fill_ctrl.sv
// fetch fill controller: linear address, icache requests, response slots and fill count
`timescale 1ns/1ps
`include "fetch_consts.svh"

module fetch_fill_ctrl (
   input  logic                          CLK,
   input  logic                          reset,

   input  logic                          redirect_valid,
   input  fetch_pkg::redirect_t          redirect,

   output logic                          icache_req_valid,
   output fetch_pkg::icache_req_t        icache_req,
   input  logic                          icache_req_ready,

   input  logic                          icache_resp_valid,
   input  fetch_pkg::icache_resp_t       icache_resp,

   input  logic                          slot_release,
   output logic [`FETCH_CNT_W-1:0]       fill_count,
   output logic [`FETCH_PTR_W-`FETCH_SLOT_W-1:0] redirect_offset,

   output logic                          line_wr_en,
   output logic [`FETCH_SLOT_W-1:0]      line_wr_slot,
   output logic [`FETCH_LINE_W-1:0]      line_wr_data
);

   localparam int OFF_W = `FETCH_PTR_W - `FETCH_SLOT_W;

   logic [`FETCH_ADDR_W-1:0] lin_addr;
   logic [`FETCH_ADDR_W-1:0] fetch_addr;
   logic                     active;
   logic                     pending;
   logic                     drop;
   logic                     req_fire;
   logic                     resp_keep;
   logic                     pending_next;
   logic                     req_raise;

   // CS:EIP to linear, CS weighted by 64K
   assign lin_addr = {redirect.cs, {(`FETCH_ADDR_W-`FETCH_SEG_W){1'b0}}} + redirect.eip;
   assign redirect_offset = lin_addr[OFF_W-1:0];

   assign req_fire = icache_req_valid && icache_req_ready;

   // stale responses from before a redirect are thrown away
   assign resp_keep = icache_resp_valid && pending && !drop && !redirect_valid;

   // one request outstanding at most, so fire and response never coincide
   assign pending_next = req_fire || (pending && !icache_resp_valid);

   // new request only when idle and a slot is guaranteed for the response
   assign req_raise = active && !redirect_valid && !icache_req_valid && !pending &&
                      (fill_count < `FETCH_CNT_W'(`FETCH_SLOTS));

   assign icache_req.addr = fetch_addr;

   assign line_wr_en   = resp_keep;
   assign line_wr_data = icache_resp.data;

   // request and response tracking
   always_ff @(posedge CLK) begin
      if (reset) begin
         active           <= 1'b0;
         icache_req_valid <= 1'b0;
         pending          <= 1'b0;
         drop             <= 1'b0;
      end else begin
         pending <= pending_next;
         if (redirect_valid) begin
            active           <= 1'b1;
            icache_req_valid <= 1'b0;
            // whatever is still in flight belongs to the old stream
            drop             <= pending_next;
         end else begin
            if (icache_resp_valid) begin
               drop <= 1'b0;
            end
            if (req_fire) begin
               icache_req_valid <= 1'b0;
            end else if (req_raise) begin
               icache_req_valid <= 1'b1;
            end
         end
      end
   end

   // aligned fetch address, next line after each accepted request
   always_ff @(posedge CLK) begin
      if (redirect_valid) begin
         fetch_addr <= {lin_addr[`FETCH_ADDR_W-1:OFF_W], {OFF_W{1'b0}}};
      end else if (req_fire) begin
         fetch_addr <= fetch_addr + `FETCH_ADDR_W'(`FETCH_LINE_BYTES);
      end
   end

   // write slot and filled line count
   always_ff @(posedge CLK) begin
      if (reset) begin
         line_wr_slot <= '0;
         fill_count   <= '0;
      end else if (redirect_valid) begin
         line_wr_slot <= '0;
         fill_count   <= '0;
      end else begin
         if (resp_keep) begin
            line_wr_slot <= line_wr_slot + 1'b1;
         end
         case ({resp_keep, slot_release})
            2'b10:   fill_count <= fill_count + 1'b1;
            2'b01:   fill_count <= fill_count - 1'b1;
            default: fill_count <= fill_count;
         endcase
      end
   end

endmodule

// File: fetch_read_ctrl.sv
// fetch read controller: read pointer, instruction EIP, window valid and line release
`timescale 1ns/1ps
`include "fetch_consts.svh"

module fetch_read_ctrl (
   input  logic                          CLK,
   input  logic                          reset,

   input  logic                          redirect_valid,
   input  fetch_pkg::redirect_t          redirect,
   input  logic [`FETCH_PTR_W-`FETCH_SLOT_W-1:0] redirect_offset,

   input  logic [`FETCH_CNT_W-1:0]       fill_count,

   input  logic                          ir_ready,
   input  logic [`FETCH_LEN_W-1:0]       instr_len,
   output logic                          ir_valid,

   output logic [`FETCH_PTR_W-1:0]       read_ptr,
   output logic [`FETCH_ADDR_W-1:0]      window_eip,
   output logic                          slot_release
);

   localparam int OFF_W = `FETCH_PTR_W - `FETCH_SLOT_W;

   logic                    consume;
   logic [`FETCH_PTR_W-1:0] read_ptr_next;
   logic                    line_start;

   assign line_start = (read_ptr[OFF_W-1:0] == '0);

   // a full 16-byte window must be present from read_ptr onward
   assign ir_valid = (fill_count >= `FETCH_CNT_W'(2)) ||
                     ((fill_count == `FETCH_CNT_W'(1)) && line_start);

   assign consume       = ir_valid && ir_ready;
   assign read_ptr_next = read_ptr + `FETCH_PTR_W'(instr_len);

   // length is at most 15, so one consume crosses at most one line
   assign slot_release = consume && !redirect_valid &&
                         (read_ptr_next[`FETCH_PTR_W-1:OFF_W] != read_ptr[`FETCH_PTR_W-1:OFF_W]);

   always_ff @(posedge CLK) begin
      if (reset) begin
         read_ptr <= '0;
      end else if (redirect_valid) begin
         // new stream starts in slot 0 at the target's byte offset
         read_ptr <= {{`FETCH_SLOT_W{1'b0}}, redirect_offset};
      end else if (consume) begin
         read_ptr <= read_ptr_next;
      end
   end

   // EIP of the instruction at read_ptr
   always_ff @(posedge CLK) begin
      if (redirect_valid) begin
         window_eip <= redirect.eip;
      end else if (consume) begin
         window_eip <= window_eip + `FETCH_ADDR_W'(instr_len);
      end
   end

endmodule

// File: fetch_line_buffer.sv
// fetch line buffer: four 16-byte line registers written one slot at a time
`timescale 1ns/1ps
`include "fetch_consts.svh"

module fetch_line_buffer (
   input  logic                     CLK,
   input  logic                     reset,

   input  logic                     line_wr_en,
   input  logic [`FETCH_SLOT_W-1:0] line_wr_slot,
   input  logic [`FETCH_LINE_W-1:0] line_wr_data,

   output fetch_pkg::line_array_t   lines
);

   // circular storage, the slot index comes from the fill controller
   always_ff @(posedge CLK) begin
      if (reset) begin
         lines <= '0;
      end else if (line_wr_en) begin
         lines[line_wr_slot] <= line_wr_data;
      end
   end

endmodule

// File: instr_aligner.sv
// instruction aligner: joins two adjacent lines and byte-shifts them into the decode window
`timescale 1ns/1ps
`include "fetch_consts.svh"

module instr_aligner (
   input  fetch_pkg::line_array_t   lines,
   input  logic [`FETCH_PTR_W-1:0]  read_ptr,
   output logic [`FETCH_LINE_W-1:0] window_bytes
);

   localparam int OFF_W = `FETCH_PTR_W - `FETCH_SLOT_W;

   logic [`FETCH_SLOT_W-1:0]   cur_slot;
   logic [`FETCH_SLOT_W-1:0]   nxt_slot;
   logic [OFF_W-1:0]           offset;
   logic [2*`FETCH_LINE_W-1:0] pair;

   assign cur_slot = read_ptr[`FETCH_PTR_W-1:OFF_W];
   assign offset   = read_ptr[OFF_W-1:0];

   // slot after the last one is slot 0
   assign nxt_slot = cur_slot + 1'b1;

   // little-endian, the current line holds the low bytes
   assign pair = {lines[nxt_slot], lines[cur_slot]};

   // window byte i is pair byte offset + i
   always_comb begin
      int src;
      for (int i = 0; i < `FETCH_LINE_BYTES; i++) begin
         src = int'(offset) + i;
         window_bytes[8*i +: 8] = pair[8*src +: 8];
      end
   end

endmodule

// File: fetch_top.sv
// fetch unit top: icache fill, line buffer, read pointer and aligner to the decoder
`timescale 1ns/1ps
`include "fetch_consts.svh"

module fetch_top (
   input  logic                      CLK,
   input  logic                      reset,

   input  logic                      redirect_valid,
   input  fetch_pkg::redirect_t      redirect,

   output logic                      icache_req_valid,
   output fetch_pkg::icache_req_t    icache_req,
   input  logic                      icache_req_ready,

   input  logic                      icache_resp_valid,
   input  fetch_pkg::icache_resp_t   icache_resp,

   output logic                      ir_valid,
   output fetch_pkg::fetch_window_t  ir_window,
   input  logic                      ir_ready,

   input  logic [`FETCH_LEN_W-1:0]   instr_len
);

   import fetch_pkg::*;

   logic                                 line_wr_en;
   logic [`FETCH_SLOT_W-1:0]             line_wr_slot;
   logic [`FETCH_LINE_W-1:0]             line_wr_data;
   logic [`FETCH_CNT_W-1:0]              fill_count;
   logic [`FETCH_PTR_W-`FETCH_SLOT_W-1:0] redirect_offset;
   logic                                 slot_release;
   logic [`FETCH_PTR_W-1:0]              read_ptr;
   logic [`FETCH_ADDR_W-1:0]             window_eip;
   logic [`FETCH_LINE_W-1:0]             window_bytes;
   line_array_t                          lines;

   fetch_fill_ctrl u_fill_ctrl (
      .CLK               (CLK),
      .reset             (reset),
      .redirect_valid    (redirect_valid),
      .redirect          (redirect),
      .icache_req_valid  (icache_req_valid),
      .icache_req        (icache_req),
      .icache_req_ready  (icache_req_ready),
      .icache_resp_valid (icache_resp_valid),
      .icache_resp       (icache_resp),
      .slot_release      (slot_release),
      .fill_count        (fill_count),
      .redirect_offset   (redirect_offset),
      .line_wr_en        (line_wr_en),
      .line_wr_slot      (line_wr_slot),
      .line_wr_data      (line_wr_data)
   );

   fetch_read_ctrl u_read_ctrl (
      .CLK             (CLK),
      .reset           (reset),
      .redirect_valid  (redirect_valid),
      .redirect        (redirect),
      .redirect_offset (redirect_offset),
      .fill_count      (fill_count),
      .ir_ready        (ir_ready),
      .instr_len       (instr_len),
      .ir_valid        (ir_valid),
      .read_ptr        (read_ptr),
      .window_eip      (window_eip),
      .slot_release    (slot_release)
   );

   fetch_line_buffer u_line_buffer (
      .CLK          (CLK),
      .reset        (reset),
      .line_wr_en   (line_wr_en),
      .line_wr_slot (line_wr_slot),
      .line_wr_data (line_wr_data),
      .lines        (lines)
   );

   instr_aligner u_aligner (
      .lines        (lines),
      .read_ptr     (read_ptr),
      .window_bytes (window_bytes)
   );

   // aligned bytes travel with the EIP of their first byte
   assign ir_window.bytes = window_bytes;
   assign ir_window.eip   = window_eip;

endmodule

// File: tb_icache_model.sv
// instruction cache model: random accept and latency, line contents computed from the address
`timescale 1ns/1ps
`include "fetch_consts.svh"

module tb_icache_model #(
   parameter int SEED = 93661
) (
   input  logic                    CLK,
   input  logic                    reset,

   input  logic                    icache_req_valid,
   input  fetch_pkg::icache_req_t  icache_req,
   output logic                    icache_req_ready,

   output logic                    icache_resp_valid,
   output fetch_pkg::icache_resp_t icache_resp
);

   integer                   seed;
   logic                     busy;
   integer                   wait_cnt;
   logic [`FETCH_ADDR_W-1:0] line_addr;

   // byte at a is its low address byte mixed with the next byte up
   function automatic logic [7:0] mem_byte(input logic [`FETCH_ADDR_W-1:0] a);
      return a[7:0] ^ a[15:8];
   endfunction

   function automatic logic [`FETCH_LINE_W-1:0] line_data(input logic [`FETCH_ADDR_W-1:0] a);
      logic [`FETCH_LINE_W-1:0] d;
      for (int i = 0; i < `FETCH_LINE_BYTES; i++) begin
         d[8*i +: 8] = mem_byte(a + i);
      end
      return d;
   endfunction

   initial begin
      seed              = SEED;
      busy              = 1'b0;
      wait_cnt          = 0;
      line_addr         = '0;
      icache_req_ready  = 1'b0;
      icache_resp_valid = 1'b0;
      icache_resp       = '0;
   end

   // one line in flight at a time
   always @(posedge CLK) begin
      if (reset) begin
         busy              = 1'b0;
         icache_req_ready  <= 1'b0;
         icache_resp_valid <= 1'b0;
      end else begin
         icache_resp_valid <= 1'b0;
         if (busy) begin
            if (wait_cnt == 0) begin
               icache_resp_valid <= 1'b1;
               icache_resp.data  <= line_data(line_addr);
               busy = 1'b0;
            end else begin
               wait_cnt = wait_cnt - 1;
            end
         end else if (icache_req_valid && icache_req_ready) begin
            busy      = 1'b1;
            line_addr = icache_req.addr;
            wait_cnt  = {$random(seed)} % 4;
         end
         icache_req_ready <= !busy && ({$random(seed)} % 2 == 0);
      end
   end

endmodule

// File: tb_fetch_top.sv
// fetch unit testbench: redirects, random decoder and cache, window and request checks
`timescale 1ns/1ps
`include "fetch_consts.svh"

module tb_fetch_top;

   import fetch_pkg::*;

   localparam int MAX_CYCLES = 4000;
   localparam int CONSUMES_PER_RUN = 30;

   logic CLK;
   logic reset;
   logic redirect_valid;
   redirect_t redirect;
   logic icache_req_valid;
   icache_req_t icache_req;
   logic icache_req_ready;
   logic icache_resp_valid;
   icache_resp_t icache_resp;
   logic ir_valid;
   fetch_window_t ir_window;
   logic ir_ready;
   logic [`FETCH_LEN_W-1:0] instr_len;

   integer seed;
   integer cycles;
   integer error_count;
   integer req_count;
   integer rel_count;
   integer consumes;
   logic seen_redirect;
   logic stall;
   logic pend;
   logic [`FETCH_ADDR_W-1:0] exp_eip;
   logic [`FETCH_ADDR_W-1:0] exp_lin;
   logic [`FETCH_ADDR_W-1:0] exp_req;
   logic [`FETCH_PTR_W-1:0] tb_ptr;
   logic [`FETCH_PTR_W-1:0] nxt_ptr;

   fetch_top dut0 (.*);

   tb_icache_model #(.SEED(93661)) icache0 (.*);

   initial begin
      CLK = 1'b0;
      forever #10 CLK = ~CLK;
   end

   function automatic logic [`FETCH_LINE_W-1:0] expect_bytes(input logic [31:0] a);
      logic [`FETCH_LINE_W-1:0] d;
      for (int i = 0; i < `FETCH_LINE_BYTES; i++) begin
         d[8*i +: 8] = 8'((a + i) ^ ((a + i) >> 8));
      end
      return d;
   endfunction

   task automatic report_mismatch(input string test, input logic [127:0] exp_v,
                                  input logic [127:0] act_v);
      error_count = error_count + 1;
      $display("** Error [%s] expected %h actual %h", test, exp_v, act_v);
      $display("RESULT: FAIL");
      $fatal(1);
   endtask

   task automatic report_failure(input string msg);
      error_count = error_count + 1;
      $display("%s", msg);
      $display("RESULT: FAIL");
      $fatal(1);
   endtask

   // window holds still while the decoder stalls
   assert property (@(posedge CLK) disable iff (reset)
                    (ir_valid && !ir_ready && !redirect_valid) |=> $stable(ir_window))
      else report_failure("window changed while the decoder was stalled");

   always @(posedge CLK) begin
      cycles = cycles + 1;
      if (cycles >= MAX_CYCLES) begin
         report_failure("timeout, the run did not finish within the cycle limit");
      end
   end

   // reference model of the request stream and the consumed windows
   always @(posedge CLK) begin
      if (!reset) begin
         if (!seen_redirect) begin
            assert (!icache_req_valid && !ir_valid)
               else report_failure("request or window valid before the first redirect");
         end
         if (icache_resp_valid) begin
            pend = 1'b0;
         end
         if (icache_req_valid && icache_req_ready) begin
            pend = 1'b1;
         end
         if (redirect_valid) begin
            seen_redirect = 1'b1;
            exp_eip   = redirect.eip;
            exp_lin   = {redirect.cs, 16'h0000} + redirect.eip;
            exp_req   = {exp_lin[31:4], 4'h0};
            tb_ptr    = {2'b00, exp_lin[3:0]};
            req_count = 0;
            rel_count = 0;
            consumes  = 0;
         end else begin
            if (icache_req_valid && icache_req_ready) begin
               assert (icache_req.addr == exp_req)
                  else report_mismatch("request address", 128'(exp_req), 128'(icache_req.addr));
               exp_req   = exp_req + 16;
               req_count = req_count + 1;
            end
            if (ir_valid && ir_ready) begin
               assert (ir_window.eip == exp_eip)
                  else report_mismatch("window eip", 128'(exp_eip), 128'(ir_window.eip));
               assert (ir_window.bytes == expect_bytes(exp_lin))
                  else report_mismatch("window bytes", expect_bytes(exp_lin), ir_window.bytes);
               nxt_ptr = tb_ptr + instr_len;
               if (nxt_ptr[5:4] != tb_ptr[5:4]) begin
                  rel_count = rel_count + 1;
               end
               tb_ptr   = nxt_ptr;
               exp_eip  = exp_eip + instr_len;
               exp_lin  = exp_lin + instr_len;
               consumes = consumes + 1;
            end
            assert (req_count - rel_count <= 4)
               else report_failure("more than four lines requested and not released");
         end
      end
   end

   // decoder model
   always @(posedge CLK) begin
      if (!reset) begin
         ir_ready  <= !stall && ({$random(seed)} % 2 == 0);
         instr_len <= `FETCH_LEN_W'(1 + ({$random(seed)} % 15));
      end
   end

   initial begin
      seed = 93661;
      cycles = 0;
      error_count = 0;
      req_count = 0;
      rel_count = 0;
      consumes = 0;
      seen_redirect = 1'b0;
      stall = 1'b0;
      pend = 1'b0;
      reset = 1'b1;
      redirect_valid = 1'b0;
      redirect = '0;
      ir_ready = 1'b0;
      instr_len = 1;
      repeat (3) @(posedge CLK);
      reset <= 1'b0;
      repeat (10) @(posedge CLK);
      for (int r = 0; r < 9; r++) begin
         // mode 1 redirects with a line in flight, mode 2 with the queue full
         if (r % 3 == 1) begin
            while (!pend) @(posedge CLK);
         end else if (r % 3 == 2) begin
            stall <= 1'b1;
            while (req_count - rel_count < 4 || pend) @(posedge CLK);
            repeat (3) @(posedge CLK);
         end
         redirect_valid <= 1'b1;
         redirect.cs    <= `FETCH_SEG_W'($random(seed));
         redirect.eip   <= $random(seed);
         @(posedge CLK);
         redirect_valid <= 1'b0;
         stall <= 1'b0;
         @(posedge CLK);
         while (consumes < CONSUMES_PER_RUN) @(posedge CLK);
      end
      if (error_count == 0) begin
         $display("RESULT: PASS");
      end else begin
         $display("RESULT: FAIL");
      end
      $finish;
   end

endmodule

// File: flist.f
+incdir+.
fetch_pkg.sv
fetch_fill_ctrl.sv
fetch_read_ctrl.sv
fetch_line_buffer.sv
instr_aligner.sv
fetch_top.sv
tb_icache_model.sv
tb_fetch_top.sv

// File: run_sim.sh
#!/bin/sh
# Verilator build and run of the fetch unit testbench

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
   --top-module tb_fetch_top -f flist.f -o sim_fetch
if [ $? -ne 0 ]; then
   echo "compile failed"
   exit 1
fi

./obj_dir/sim_fetch > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
fi

if grep -q "RESULT: PASS" sim.log; then
   exit 0
fi
exit 1
